//--- Makefile
# Verilator build and run of the register file testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= tb_regfile_subsys
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJ_DIR)

//--- design/apb_debug_port.sv
module apb_debug_port #(
	parameter int WID = regfile_pkg::reg_width
) (
	input logic rclk,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input regfile_pkg::apb_addr_t paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output regfile_pkg::mode_t mode,
	rf_write_if.requester wr,
	output regfile_pkg::phys_addr_t rd_addr,
	input logic [WID-1:0] rd_data
);
	import regfile_pkg::*;

	// ==================================================
	// address decode
	// ==================================================

	logic access;
	logic sel_mode;
	logic sel_win;
	logic sel_hi;
	logic mapped;
	// window access kinds
	logic lo_wr;
	logic hi_wr;
	logic lo_rd;

	// second access cycle of a low-half read
	logic rd_wait;

	// low half waiting for the committing high write
	logic [31:0] lo_hold;
	// high half captured by the last low-half read
	logic [31:0] hi_latch;

	// storage side seen as a 64-bit pair of halves
	logic [63:0] rd_wide;
	logic [63:0] wr_wide;

	assign access = psel && penable;

	// mode register is a single word
	assign sel_mode = (paddr == mode_reg_addr);
	// window only takes word aligned addresses
	assign sel_win = ((paddr & reg_window_base) != '0) && (paddr[1:0] == 2'b00);
	assign sel_hi = paddr[2];
	assign mapped = sel_mode || sel_win;

	assign lo_wr = access && sel_win && pwrite && !sel_hi;
	assign hi_wr = access && sel_win && pwrite && sel_hi;
	assign lo_rd = access && sel_win && !pwrite && !sel_hi;

	// ==================================================
	// storage access
	// ==================================================

	// read address straight from paddr
	// storage registers it, data comes back one cycle later
	assign rd_addr = paddr[10:3];
	assign rd_wide = 64'(rd_data);

	// high write commits both halves in one request
	assign wr_wide = {pwdata, lo_hold};
	assign wr.req = hi_wr;
	assign wr.addr = paddr[10:3];
	assign wr.data = WID'(wr_wide);

	// ==================================================
	// apb response
	// ==================================================

	always_comb begin
		pready = 1'b0;
		pslverr = 1'b0;
		prdata = '0;
		if (access) begin
			if (!mapped) begin
				// unmapped, finish at once with an error
				pready = 1'b1;
				pslverr = 1'b1;
			end else if (sel_mode) begin
				pready = 1'b1;
				prdata = 32'(mode);
			end else if (pwrite) begin
				// high write waits for the arbiter, low write is a plain load
				pready = sel_hi ? wr.gnt : 1'b1;
			end else if (sel_hi) begin
				pready = 1'b1;
				prdata = hi_latch;
			end else begin
				// low read finishes once the storage data is back
				pready = rd_wait;
				prdata = rd_wide[31:0];
			end
		end
	end

	// ==================================================
	// state
	// ==================================================

	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			mode <= '0;
			rd_wait <= 1'b0;
		end else begin
			if (access && sel_mode && pwrite) begin
				mode <= mode_t'(pwdata[1:0]);
			end
			// high in the second low-read cycle only, an aborted read drops it
			rd_wait <= lo_rd && !rd_wait;
		end
	end

	// halves carry data only, no reset
	always_ff @(posedge rclk) begin
		if (lo_wr) begin
			lo_hold <= pwdata;
		end
		if (lo_rd && rd_wait) begin
			hi_latch <= rd_wide[63:32];
		end
	end

endmodule

//--- design/regfile_2w6r.sv
module regfile_2w6r #(
	parameter int WID = regfile_pkg::reg_width
) (
	input logic rclk,
	input logic arst_n,
	input regfile_pkg::mode_t mode,
	rf_write_if.bank wp0,
	rf_write_if.bank wp1,
	input regfile_pkg::reg_idx_t [4:0] ra,
	input regfile_pkg::phys_addr_t dbg_ra,
	output logic [4:0][WID-1:0] rd,
	output logic [WID-1:0] dbg_rd
);
	import regfile_pkg::*;

	// five core read ports plus the debug port
	localparam int n_rd = 6;

	// ==================================================
	// storage
	// ==================================================

	// one array per write port, so each array has a single writer
	logic [WID-1:0] regs0 [num_phys];
	logic [WID-1:0] regs1 [num_phys];

	// live-value table
	// bit set means regs1 holds the newest copy of that entry
	logic [num_phys-1:0] lvt;

	// registered read addresses, index 5 is the debug port
	phys_addr_t ra_nxt [n_rd];
	phys_addr_t rra [n_rd];

	// per-port read result before splitting into core and debug outputs
	logic [WID-1:0] rd_all [n_rd];

	// write port 0 only ever touches regs0
	always_ff @(posedge rclk) begin
		if (wp0.req) begin
			regs0[wp0.addr] <= wp0.data;
		end
	end

	// write port 1 only ever touches regs1
	always_ff @(posedge rclk) begin
		if (wp1.req) begin
			regs1[wp1.addr] <= wp1.data;
		end
	end

	// track the last writer of each entry
	// port 1 assignment comes last, so it wins a same-address collision
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			lvt <= '0;
		end else begin
			if (wp0.req) begin
				lvt[wp0.addr] <= 1'b0;
			end
			if (wp1.req) begin
				lvt[wp1.addr] <= 1'b1;
			end
		end
	end

	// ==================================================
	// read address capture
	// ==================================================

	// core indices are banked by the mode seen at the capture edge
	for (genvar i = 0; i < n_rd - 1; i++) begin : g_core_addr
		assign ra_nxt[i] = bank_addr(mode, ra[i]);
	end

	// debug address is already physical
	assign ra_nxt[n_rd-1] = dbg_ra;

	always_ff @(posedge rclk) begin
		for (int i = 0; i < n_rd; i++) begin
			rra[i] <= ra_nxt[i];
		end
	end

	// ==================================================
	// read data
	// ==================================================

	// priority: zero register, port 1 bypass, port 0 bypass, then the lvt pick
	// index 0 reads zero whatever the bank field says
	for (genvar i = 0; i < n_rd; i++) begin : g_rd
		assign rd_all[i] = (rra[i][5:0] == 6'd0) ? '0 :
			(wp1.req && (wp1.addr == rra[i])) ? wp1.data :
			(wp0.req && (wp0.addr == rra[i])) ? wp0.data :
			lvt[rra[i]] ? regs1[rra[i]] : regs0[rra[i]];
	end

	// split results back onto the core and debug outputs
	for (genvar i = 0; i < n_rd - 1; i++) begin : g_rd_out
		assign rd[i] = rd_all[i];
	end

	assign dbg_rd = rd_all[n_rd-1];

endmodule

//--- design/regfile_pkg.sv
package regfile_pkg;

	// ==================================================
	// widths and types
	// ==================================================

	// register width, passed down as WID
	localparam int reg_width = 64;

	// physical entries, four banks of 64
	localparam int num_phys = 256;

	typedef logic [reg_width-1:0] word_t;
	typedef logic [5:0] reg_idx_t;
	// bank in [7:6], index in [5:0]
	typedef logic [7:0] phys_addr_t;
	typedef logic [1:0] mode_t;
	typedef logic [11:0] apb_addr_t;

	// ==================================================
	// apb map
	// ==================================================

	localparam apb_addr_t mode_reg_addr = 12'h000;
	// window bits 10:3 carry the physical address, bit 2 the half
	localparam apb_addr_t reg_window_base = 12'h800;

	// registers 0..7 are common to all modes, so they always map into bank 0
	function automatic phys_addr_t bank_addr(mode_t mode, reg_idx_t idx);
		mode_t bank;
		bank = (idx[5:3] != 3'b000) ? mode : 2'b00;
		return {bank, idx};
	endfunction

endpackage

//--- design/regfile_subsys.sv
module regfile_subsys #(
	parameter int WID = regfile_pkg::reg_width
) (
	input logic rclk,
	input logic arst_n,
	// core write ports
	input logic wr0_en,
	input regfile_pkg::reg_idx_t wr0_idx,
	input logic [WID-1:0] wr0_data,
	input logic wr1_en,
	input regfile_pkg::reg_idx_t wr1_idx,
	input logic [WID-1:0] wr1_data,
	// core read ports
	input regfile_pkg::reg_idx_t ra0,
	input regfile_pkg::reg_idx_t ra1,
	input regfile_pkg::reg_idx_t ra2,
	input regfile_pkg::reg_idx_t ra3,
	input regfile_pkg::reg_idx_t ra4,
	output logic [WID-1:0] rd0,
	output logic [WID-1:0] rd1,
	output logic [WID-1:0] rd2,
	output logic [WID-1:0] rd3,
	output logic [WID-1:0] rd4,
	// apb debug slave
	input logic psel,
	input logic penable,
	input logic pwrite,
	input regfile_pkg::apb_addr_t paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	import regfile_pkg::*;

	// mode from the debug port, used for banking in arbiter and storage
	mode_t mode;
	// debug read path through storage port 5
	phys_addr_t dbg_ra;
	logic [WID-1:0] dbg_rd;

	rf_write_if #(.WID(WID)) dbg_wr ();
	rf_write_if #(.WID(WID)) bank_wr0 ();
	rf_write_if #(.WID(WID)) bank_wr1 ();

	apb_debug_port #(.WID(WID)) i_dbg (
		.rclk(rclk),
		.arst_n(arst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.mode(mode),
		.wr(dbg_wr.requester),
		.rd_addr(dbg_ra),
		.rd_data(dbg_rd)
	);

	write_path_arbiter #(.WID(WID)) i_arb (
		.mode(mode),
		.wr0_en(wr0_en),
		.wr1_en(wr1_en),
		.wr0_idx(wr0_idx),
		.wr1_idx(wr1_idx),
		.wr0_data(wr0_data),
		.wr1_data(wr1_data),
		.dbg(dbg_wr.arbiter),
		.bank0(bank_wr0.requester),
		.bank1(bank_wr1.requester)
	);

	regfile_2w6r #(.WID(WID)) i_rf (
		.rclk(rclk),
		.arst_n(arst_n),
		.mode(mode),
		.wp0(bank_wr0.bank),
		.wp1(bank_wr1.bank),
		.ra({ra4, ra3, ra2, ra1, ra0}),
		.dbg_ra(dbg_ra),
		.rd({rd4, rd3, rd2, rd1, rd0}),
		.dbg_rd(dbg_rd)
	);

endmodule

//--- design/rf_write_if.sv
interface rf_write_if #(
	parameter int WID = regfile_pkg::reg_width
);
	import regfile_pkg::*;

	// request and its payload, held until gnt is seen at an edge
	logic req;
	phys_addr_t addr;
	logic [WID-1:0] data;
	// grant, the edge with req and gnt high performs the write
	logic gnt;

	modport requester (output req, output addr, output data, input gnt);
	modport arbiter (input req, input addr, input data, output gnt);
	// storage side always accepts, so no grant here
	modport bank (input req, input addr, input data);

endinterface

//--- design/write_path_arbiter.sv
module write_path_arbiter #(
	parameter int WID = regfile_pkg::reg_width
) (
	input regfile_pkg::mode_t mode,
	input logic wr0_en,
	input logic wr1_en,
	input regfile_pkg::reg_idx_t wr0_idx,
	input regfile_pkg::reg_idx_t wr1_idx,
	input logic [WID-1:0] wr0_data,
	input logic [WID-1:0] wr1_data,
	rf_write_if.arbiter dbg,
	rf_write_if.requester bank0,
	rf_write_if.requester bank1
);
	import regfile_pkg::*;

	// banked core write addresses
	phys_addr_t wa0;
	phys_addr_t wa1;

	// debug owns port 1 only in a cycle the core leaves free
	logic dbg_own;

	assign wa0 = bank_addr(mode, wr0_idx);
	assign wa1 = bank_addr(mode, wr1_idx);

	// ==================================================
	// port 0, core only
	// ==================================================

	assign bank0.req = wr0_en;
	assign bank0.addr = wa0;
	assign bank0.data = wr0_data;

	// ==================================================
	// port 1, core first then debug
	// ==================================================

	assign dbg_own = !wr1_en;

	// grant in the same cycle, the requester keeps holding until it sees this
	assign dbg.gnt = dbg.req && dbg_own;

	assign bank1.req = wr1_en || dbg.req;
	assign bank1.addr = dbg_own ? dbg.addr : wa1;
	assign bank1.data = dbg_own ? dbg.data : wr1_data;

endmodule

//--- filelist.f
+incdir+testbench
design/regfile_pkg.sv
design/rf_write_if.sv
design/regfile_2w6r.sv
design/write_path_arbiter.sv
design/apb_debug_port.sv
design/regfile_subsys.sv
testbench/tb_regfile_subsys.sv

//--- testbench/tb_regfile_tasks.svh
// ==================================================
// helpers
// ==================================================

// 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit taken
function automatic word_t rand_bits(input int n);
	word_t v;
	logic fb;
	int i;
	v = '0;
	for (i = 0; i < n; i++) begin
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		v = (v << 1) | word_t'(fb);
	end
	return v;
endfunction

// indices below 8 are shared, so they sit in bank 0 in every mode
function automatic phys_addr_t model_addr(input mode_t m, input reg_idx_t idx);
	if (idx < 6'd8) begin
		return {2'b00, idx};
	end
	return {m, idx};
endfunction

// register window: bit 11 set, physical address in 10:3, half in bit 2
function automatic apb_addr_t win_addr(input phys_addr_t pa, input logic hi);
	return {1'b1, pa, hi, 2'b00};
endfunction

task automatic compare_word(input string name, input word_t got, input word_t want);
	if (got !== want) begin
		value_errs++;
		$display("error at %0t: %s got %h expected %h", $time, name, got, want);
	end
endtask

task automatic compare_half(input string name, input logic [31:0] got,
		input logic [31:0] want);
	if (got !== want) begin
		value_errs++;
		$display("error at %0t: %s got %h expected %h", $time, name, got, want);
	end
endtask

// transfer outcome, pslverr as seen with pready high
task automatic compare_resp(input string name, input logic got, input logic want);
	if (got !== want) begin
		value_errs++;
		$display("error at %0t: %s got %b expected %b", $time, name, got, want);
	end
endtask

task automatic wait_check(input string what, input int got, input int want);
	if (got != want) begin
		other_errs++;
		$display("%s at %0t took %0d wait states instead of %0d", what, $time, got, want);
	end
endtask

// ==================================================
// bus drivers
// ==================================================

// setup cycle, then access until pready
// waits counts access cycles with pready still low
task automatic apb_xfer(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err, output int waits);
	waits = 0;
	@(posedge rclk);
	psel <= 1'b1;
	penable <= 1'b0;
	pwrite <= wr;
	paddr <= addr;
	pwdata <= wdata;
	@(posedge rclk);
	penable <= 1'b1;
	@(negedge rclk);
	while (!pready) begin
		waits++;
		@(negedge rclk);
	end
	rdata = prdata;
	err = pslverr;
	// completing edge, bus goes idle after it
	@(posedge rclk);
	psel <= 1'b0;
	penable <= 1'b0;
	pwrite <= 1'b0;
endtask

task automatic mode_set(input mode_t m);
	logic [31:0] rdata;
	logic err;
	int waits;
	apb_xfer(1'b1, 12'h000, {30'b0, m}, rdata, err, waits);
	compare_resp("pslverr mode write", err, 1'b0);
	wait_check("mode write", waits, 0);
	cur_mode = m;
endtask

task automatic mode_check();
	logic [31:0] rdata;
	logic err;
	int waits;
	apb_xfer(1'b0, 12'h000, 32'h0, rdata, err, waits);
	compare_resp("pslverr mode read", err, 1'b0);
	wait_check("mode read", waits, 0);
	compare_half("prdata mode", rdata, {30'b0, cur_mode});
endtask

task automatic dbg_write(input phys_addr_t pa, input word_t val);
	logic [31:0] rdata;
	logic err;
	int waits;
	apb_xfer(1'b1, win_addr(pa, 1'b0), val[31:0], rdata, err, waits);
	compare_resp("pslverr debug low write", err, 1'b0);
	wait_check("debug low write", waits, 0);
	// port 1 idle, grant in the first access cycle
	apb_xfer(1'b1, win_addr(pa, 1'b1), val[63:32], rdata, err, waits);
	compare_resp("pslverr debug high write", err, 1'b0);
	wait_check("debug high write", waits, 0);
	model_regs[pa] = val;
endtask

task automatic dbg_check(input phys_addr_t pa);
	logic [31:0] lo;
	logic [31:0] hi;
	logic err;
	int waits;
	word_t want;
	want = (pa[5:0] == 6'd0) ? '0 : model_regs[pa];
	// low half needs one cycle for the storage read
	apb_xfer(1'b0, win_addr(pa, 1'b0), 32'h0, lo, err, waits);
	compare_resp("pslverr debug low read", err, 1'b0);
	wait_check("debug low read", waits, 1);
	// high half comes from the latch
	apb_xfer(1'b0, win_addr(pa, 1'b1), 32'h0, hi, err, waits);
	compare_resp("pslverr debug high read", err, 1'b0);
	wait_check("debug high read", waits, 0);
	compare_half($sformatf("prdata low of phys %h", pa), lo, want[31:0]);
	compare_half($sformatf("prdata high of phys %h", pa), hi, want[63:32]);
endtask

task automatic core_write(input int port, input reg_idx_t idx, input word_t val);
	@(posedge rclk);
	if (port == 0) begin
		wr0_en <= 1'b1;
		wr0_idx <= idx;
		wr0_data <= val;
	end else begin
		wr1_en <= 1'b1;
		wr1_idx <= idx;
		wr1_data <= val;
	end
	// write lands at this edge
	@(posedge rclk);
	wr0_en <= 1'b0;
	wr1_en <= 1'b0;
	model_regs[model_addr(cur_mode, idx)] = val;
endtask

// index captured one edge after it is driven, data checked mid-cycle
task automatic core_check(input int port, input reg_idx_t idx);
	word_t want;
	want = (idx == 6'd0) ? '0 : model_regs[model_addr(cur_mode, idx)];
	@(posedge rclk);
	ra[port] <= idx;
	@(posedge rclk);
	@(negedge rclk);
	compare_word($sformatf("rd%0d idx %0d mode %0d", port, idx, cur_mode), rd[port], want);
endtask

// writes arrive in the cycle right after the read index is captured
task automatic bypass_case(input reg_idx_t idx, input logic en0, input logic en1);
	word_t d0;
	word_t d1;
	word_t want;
	phys_addr_t pa;
	d0 = rand_bits(64);
	d1 = rand_bits(64);
	pa = model_addr(cur_mode, idx);
	// port 1 over port 0 over stored value
	want = en1 ? d1 : (en0 ? d0 : model_regs[pa]);
	@(posedge rclk);
	ra[4] <= idx;
	@(posedge rclk);
	wr0_en <= en0;
	wr0_idx <= idx;
	wr0_data <= d0;
	wr1_en <= en1;
	wr1_idx <= idx;
	wr1_data <= d1;
	@(negedge rclk);
	compare_word($sformatf("rd4 bypass idx %0d", idx), rd[4], want);
	@(posedge rclk);
	wr0_en <= 1'b0;
	wr1_en <= 1'b0;
	if (en0) begin
		model_regs[pa] = d0;
	end
	// same-edge collision keeps port 1
	if (en1) begin
		model_regs[pa] = d1;
	end
	core_check(0, idx);
endtask

// ==================================================
// tests
// ==================================================

task automatic errors_and_reset_test();
	logic [31:0] rdata;
	logic err;
	int waits;
	// mode out of reset
	mode_check();
	core_write(0, 6'd9, rand_bits(64));
	apb_xfer(1'b1, 12'h004, 32'h3, rdata, err, waits);
	compare_resp("pslverr write 0x004", err, 1'b1);
	wait_check("unmapped write", waits, 0);
	// high half of phys 09 with the window bit cleared
	apb_xfer(1'b1, 12'h04c, 32'hffff_ffff, rdata, err, waits);
	compare_resp("pslverr write 0x04c", err, 1'b1);
	apb_xfer(1'b0, 12'h010, 32'h0, rdata, err, waits);
	compare_resp("pslverr read 0x010", err, 1'b1);
	wait_check("unmapped read", waits, 0);
	// mode and registers unchanged
	mode_check();
	core_check(1, 6'd9);
	core_check(3, 6'd0);
endtask

task automatic core_rw_test();
	int i;
	int m;
	for (i = 0; i < 64; i++) begin
		core_write(i % 2, reg_idx_t'(i), rand_bits(64));
		core_check(i % 5, reg_idx_t'(i));
	end
	// zero and shared registers look the same from every mode
	for (m = 1; m < 4; m++) begin
		mode_set(mode_t'(m));
		for (i = 0; i < 8; i++) begin
			core_check(i % 5, reg_idx_t'(i));
		end
	end
endtask

task automatic banking_test();
	int i;
	int m;
	for (m = 0; m < 4; m++) begin
		mode_set(mode_t'(m));
		for (i = 8; i < 16; i++) begin
			core_write(m % 2, reg_idx_t'(i), rand_bits(64));
		end
	end
	for (m = 0; m < 4; m++) begin
		mode_set(mode_t'(m));
		for (i = 8; i < 16; i++) begin
			core_check(i % 5, reg_idx_t'(i));
		end
	end
endtask

task automatic bypass_test();
	mode_set(2'd1);
	bypass_case(6'd30, 1'b1, 1'b1);
	bypass_case(6'd31, 1'b1, 1'b0);
	bypass_case(6'd5, 1'b0, 1'b1);
	bypass_case(6'd30, 1'b0, 1'b0);
endtask

task automatic debug_access_test();
	int k;
	phys_addr_t pa;
	// debug writes land in every bank and read back by halves
	for (k = 0; k < 8; k++) begin
		pa = {2'(k), 6'(16 + k)};
		dbg_write(pa, rand_bits(64));
		dbg_check(pa);
	end
	// core sees debug data, debug sees core data, per bank
	for (k = 0; k < 4; k++) begin
		mode_set(2'(k));
		core_check(k, 6'(16 + k));
		core_write(k % 2, 6'(24 + k), rand_bits(64));
		dbg_check({2'(k), 6'(24 + k)});
	end
	dbg_check(8'h03);
	dbg_write(8'h06, rand_bits(64));
	core_check(2, 6'd6);
endtask

task automatic back_pressure_test();
	logic [31:0] rdata;
	logic err;
	int waits;
	int n;
	word_t dv;
	word_t cv;
	phys_addr_t pa;
	mode_set(2'd2);
	pa = {2'd1, 6'd50};
	dv = rand_bits(64);
	cv = rand_bits(64);
	n = 2 + int'(rand_bits(3));
	apb_xfer(1'b1, win_addr(pa, 1'b0), dv[31:0], rdata, err, waits);
	compare_resp("pslverr debug low write", err, 1'b0);
	fork
		begin
			// core holds port 1 for n cycles from the setup edge
			@(posedge rclk);
			wr1_en <= 1'b1;
			wr1_idx <= 6'd50;
			wr1_data <= cv;
			repeat (n) @(posedge rclk);
			wr1_en <= 1'b0;
		end
		apb_xfer(1'b1, win_addr(pa, 1'b1), dv[63:32], rdata, err, waits);
	join
	compare_resp("pslverr debug high write", err, 1'b0);
	// access starts one cycle after the core grabs port 1
	wait_check("debug high write under core load", waits, n - 1);
	model_regs[model_addr(cur_mode, 6'd50)] = cv;
	model_regs[pa] = dv;
	core_check(1, 6'd50);
	dbg_check(pa);
endtask

//--- testbench/tb_regfile_subsys.sv
module tb_regfile_subsys;
	import regfile_pkg::*;

	// ==================================================
	// run length
	// ==================================================

	localparam int reset_cycles = 16;
	// rough cycle cost of each test, in run order
	localparam int test_cycles = 60 + 450 + 220 + 60 + 300 + 60;
	// slack for apb setup phases and wait states
	localparam int cycle_limit = reset_cycles + test_cycles + 500;

	logic rclk;
	logic arst_n;

	// core side
	logic wr0_en;
	logic wr1_en;
	reg_idx_t wr0_idx;
	reg_idx_t wr1_idx;
	word_t wr0_data;
	word_t wr1_data;
	reg_idx_t [4:0] ra;
	word_t [4:0] rd;

	// apb debug side
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	// reference model, one entry per physical register
	word_t model_regs [256];
	// mode as last written over apb
	mode_t cur_mode;
	logic [15:0] lfsr;
	int value_errs;
	int other_errs;
	int cycles = 0;

	regfile_subsys #(.WID(reg_width)) i_dut (
		.rclk(rclk),
		.arst_n(arst_n),
		.wr0_en(wr0_en),
		.wr0_idx(wr0_idx),
		.wr0_data(wr0_data),
		.wr1_en(wr1_en),
		.wr1_idx(wr1_idx),
		.wr1_data(wr1_data),
		.ra0(ra[0]),
		.ra1(ra[1]),
		.ra2(ra[2]),
		.ra3(ra[3]),
		.ra4(ra[4]),
		.rd0(rd[0]),
		.rd1(rd[1]),
		.rd2(rd[2]),
		.rd3(rd[3]),
		.rd4(rd[4]),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	`include "tb_regfile_tasks.svh"

	// ==================================================
	// clock and watchdog
	// ==================================================

	initial begin
		rclk = 1'b0;
		forever #5 rclk = ~rclk;
	end

	// a stuck handshake ends the run here
	always @(posedge rclk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run stopped after %0d cycles, a transfer never completed", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// ==================================================
	// sequence
	// ==================================================

	initial begin
		// every dut input starts at a known value
		arst_n <= 1'b0;
		wr0_en <= 1'b0;
		wr1_en <= 1'b0;
		wr0_idx <= '0;
		wr1_idx <= '0;
		wr0_data <= '0;
		wr1_data <= '0;
		ra <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		cur_mode = '0;
		lfsr = 16'd51;
		value_errs = 0;
		other_errs = 0;

		repeat (reset_cycles) @(posedge rclk);
		arst_n <= 1'b1;
		@(posedge rclk);

		// reset values first, while nothing has touched the mode
		errors_and_reset_test();
		core_rw_test();
		banking_test();
		bypass_test();
		debug_access_test();
		back_pressure_test();

		$display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
